/* hw/group_norm_pkg.sv */
// Group norm statistics engine package with group dimensions, widths and beat types
package group_norm_pkg;

    // Group geometry, a 4x4 plane in 2x2 tiles over two grouped channels
    localparam int LANES       = 4;
    localparam int GROUP_BEATS = 8;
    // log2 of the 32 values in a group, shared by mean and variance
    localparam int GROUP_SHIFT = 5;
    // Two full groups of buffering
    localparam int BUF_DEPTH   = 16;

    localparam int DATA_W = 8;
    localparam int DIFF_W = 9;
    localparam int SQ_W   = 17;
    localparam int VAR_W  = 18;

    // Signed sum of 32 input values
    localparam int SUM_W = 13;
    // Unsigned sum of 32 squares
    localparam int SSQ_W = 22;

    typedef logic signed [DATA_W-1:0] data_t;
    typedef logic signed [DIFF_W-1:0] diff_t;

    typedef struct packed {
        data_t [LANES-1:0] data;
        logic              last;
    } beat_t;

    typedef struct packed {
        data_t value;
        data_t mean;
        logic  last;
    } lane_in_t;

    typedef struct packed {
        diff_t             diff;
        logic [SQ_W-1:0]   sq;
    } lane_out_t;

    typedef struct packed {
        diff_t [LANES-1:0] diff;
        logic              last;
        logic [VAR_W-1:0]  variance;
    } out_beat_t;

endpackage

/* hw/group_buffer.sv */
// Group buffer, a circular valid/ready FIFO holding beats until their mean is ready
`timescale 1ns/1ps

module group_buffer #(
    parameter type payload_t = logic,
    parameter int  DEPTH     = 2
) (
    input  logic     clk,
    input  logic     rst,

    input  payload_t wr_data,
    input  logic     wr_valid,
    output logic     wr_ready,

    output payload_t rd_data,
    output logic     rd_valid,
    input  logic     rd_ready
);

    localparam int PTR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
    localparam int CNT_W = $clog2(DEPTH + 1);

    payload_t mem [DEPTH];

    logic [PTR_W-1:0] wr_ptr;
    logic [PTR_W-1:0] rd_ptr;
    logic [CNT_W-1:0] count;
    logic             wr_fire;
    logic             rd_fire;

    assign wr_ready = (count != CNT_W'(DEPTH));
    assign rd_valid = (count != '0);
    assign rd_data  = mem[rd_ptr];

    assign wr_fire = wr_valid && wr_ready;
    assign rd_fire = rd_valid && rd_ready;

    always_ff @(posedge clk) begin
        if (wr_fire) begin
            mem[wr_ptr] <= wr_data;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr <= '0;
            rd_ptr <= '0;
            count  <= '0;
        end else begin
            if (wr_fire) begin
                wr_ptr <= (wr_ptr == PTR_W'(DEPTH - 1)) ? '0 : wr_ptr + 1'b1;
            end
            if (rd_fire) begin
                rd_ptr <= (rd_ptr == PTR_W'(DEPTH - 1)) ? '0 : rd_ptr + 1'b1;
            end
            case ({wr_fire, rd_fire})
                2'b10:   count <= count + 1'b1;
                2'b01:   count <= count - 1'b1;
                default: count <= count;
            endcase
        end
    end

    // A full FIFO must not advance its write side, an empty one its read side
    assert property (@(posedge clk) disable iff (rst)
        (count == CNT_W'(DEPTH)) && wr_valid |=> wr_ptr == $past(wr_ptr));

    assert property (@(posedge clk) disable iff (rst)
        (count == '0) && rd_ready |=> rd_ptr == $past(rd_ptr));

endmodule

/* hw/mean_accumulator.sv */
// Mean accumulator, sums each group's 32 values and offers the group mean
`timescale 1ns/1ps

module mean_accumulator (
    input  logic                                  clk,
    input  logic                                  rst,

    input  group_norm_pkg::beat_t                 beat,
    input  logic                                  beat_valid,
    output logic                                  beat_ready,

    output logic signed [group_norm_pkg::DATA_W-1:0] mean,
    output logic                                  mean_valid,
    input  logic                                  mean_ready
);

    import group_norm_pkg::*;

    logic signed [DATA_W:0]   pair_sum [2];
    logic signed [DATA_W+1:0] beat_sum;
    logic signed [SUM_W-1:0]  acc;
    logic signed [SUM_W-1:0]  acc_next;
    logic signed [SUM_W-1:0]  mean_full;
    logic                     beat_fire;

    // Hold off new beats while a mean waits, unless it leaves this cycle
    assign beat_ready = !mean_valid || mean_ready;
    assign beat_fire  = beat_valid && beat_ready;

    // Two level adder tree over the four lanes
    always_comb begin
        pair_sum[0] = beat.data[0] + beat.data[1];
        pair_sum[1] = beat.data[2] + beat.data[3];
        beat_sum    = pair_sum[0] + pair_sum[1];
        acc_next    = acc + beat_sum;
        // Arithmetic shift, so the mean rounds toward minus infinity
        mean_full   = acc_next >>> GROUP_SHIFT;
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            acc        <= '0;
            mean_valid <= 1'b0;
        end else begin
            if (beat_fire) begin
                acc <= beat.last ? '0 : acc_next;
            end
            if (beat_fire && beat.last) begin
                mean_valid <= 1'b1;
            end else if (mean_ready) begin
                mean_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (beat_fire && beat.last) begin
            mean <= mean_full[DATA_W-1:0];
        end
    end

    // The offered mean must equal the untruncated quotient
    assert property (@(posedge clk) disable iff (rst)
        beat_fire && beat.last |=> mean_valid && (mean == $past(mean_full)));

endmodule

/* hw/norm_feeder.sv */
// Norm feeder, pairs buffered beats with their group mean and fans them out to the lanes
`timescale 1ns/1ps

module norm_feeder (
    input  logic                                     clk,
    input  logic                                     rst,

    input  logic signed [group_norm_pkg::DATA_W-1:0] mean,
    input  logic                                     mean_valid,
    output logic                                     mean_ready,

    input  group_norm_pkg::beat_t                    beat,
    input  logic                                     beat_valid,
    output logic                                     beat_ready,

    output group_norm_pkg::lane_in_t                 lanes [group_norm_pkg::LANES],
    output logic                                     lane_valid,
    input  logic                                     lane_ready
);

    import group_norm_pkg::*;

    typedef enum logic {
        ST_IDLE,
        ST_STREAM
    } state_t;

    state_t                           state;
    logic signed [DATA_W-1:0]         mean_q;
    logic [$clog2(GROUP_BEATS)-1:0]   beat_cnt;
    logic                             beat_fire;

    assign mean_ready = (state == ST_IDLE);

    // Buffer to lanes is a straight combinational path while streaming
    assign lane_valid = (state == ST_STREAM) && beat_valid;
    assign beat_ready = (state == ST_STREAM) && lane_ready;
    assign beat_fire  = lane_valid && lane_ready;

    always_comb begin
        for (int i = 0; i < LANES; i++) begin
            lanes[i].value = beat.data[i];
            lanes[i].mean  = mean_q;
            lanes[i].last  = beat.last;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state    <= ST_IDLE;
            beat_cnt <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (mean_valid) begin
                        state <= ST_STREAM;
                    end
                end
                ST_STREAM: begin
                    if (beat_fire && beat.last) begin
                        state <= ST_IDLE;
                    end
                end
                default: state <= ST_IDLE;
            endcase
            if (beat_fire) begin
                beat_cnt <= beat.last ? '0 : beat_cnt + 1'b1;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (mean_valid && mean_ready) begin
            mean_q <= mean;
        end
    end

    // Last flags from the source arrive exactly every GROUP_BEATS beats
    assert property (@(posedge clk) disable iff (rst)
        beat_fire |-> (beat.last == (beat_cnt == GROUP_BEATS - 1)));

endmodule

/* hw/center_lane.sv */
// Center lane, registers one value's difference from the mean and its square
`timescale 1ns/1ps

module center_lane (
    input  logic                      clk,
    input  logic                      rst,

    input  group_norm_pkg::lane_in_t  item,
    input  logic                      item_valid,
    output logic                      item_ready,

    output group_norm_pkg::lane_out_t result,
    output logic                      result_valid,
    input  logic                      result_ready,
    output logic                      last
);

    import group_norm_pkg::*;

    diff_t                     diff;
    logic signed [2*DIFF_W-1:0] prod;
    logic                      item_fire;

    // Single register stage that stalls in place
    assign item_ready = !result_valid || result_ready;
    assign item_fire  = item_valid && item_ready;

    // Widen before subtracting so the full range survives
    assign diff = item.value - item.mean;
    assign prod = diff * diff;

    always_ff @(posedge clk) begin
        if (rst) begin
            result_valid <= 1'b0;
        end else if (item_fire) begin
            result_valid <= 1'b1;
        end else if (result_ready) begin
            result_valid <= 1'b0;
        end
    end

    always_ff @(posedge clk) begin
        if (item_fire) begin
            result.diff <= diff;
            // Square never exceeds 255*255 so the low bits hold it all
            result.sq   <= prod[SQ_W-1:0];
            last        <= item.last;
        end
    end

endmodule

/* hw/variance_collector.sv */
// Variance collector, packs lane results into output beats and accumulates the group variance
`timescale 1ns/1ps

module variance_collector (
    input  logic                       clk,
    input  logic                       rst,

    input  group_norm_pkg::lane_out_t  results [group_norm_pkg::LANES],
    input  logic                       results_valid,
    output logic                       results_ready,
    input  logic                       last,

    output group_norm_pkg::out_beat_t  out_beat,
    output logic                       out_valid,
    input  logic                       out_ready
);

    import group_norm_pkg::*;

    logic [SQ_W+1:0]  sq_sum;
    logic [SSQ_W-1:0] ssq;
    logic [SSQ_W-1:0] ssq_next;
    logic             fire;

    assign results_ready = !out_valid || out_ready;
    assign fire          = results_valid && results_ready;

    // Sum of the four lane squares, then into the running group total
    always_comb begin
        sq_sum = '0;
        for (int i = 0; i < LANES; i++) begin
            sq_sum = sq_sum + results[i].sq;
        end
        ssq_next = ssq + SSQ_W'(sq_sum);
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            ssq       <= '0;
            out_valid <= 1'b0;
        end else begin
            if (fire) begin
                ssq       <= last ? '0 : ssq_next;
                out_valid <= 1'b1;
            end else if (out_ready) begin
                out_valid <= 1'b0;
            end
        end
    end

    always_ff @(posedge clk) begin
        if (fire) begin
            for (int i = 0; i < LANES; i++) begin
                out_beat.diff[i] <= results[i].diff;
            end
            out_beat.last <= last;
            // Variance only rides on the closing beat of a group
            if (last) begin
                out_beat.variance <= VAR_W'(ssq_next >> GROUP_SHIFT);
            end else begin
                out_beat.variance <= '0;
            end
        end
    end

    // A stalled output must hold its beat unchanged
    assert property (@(posedge clk) disable iff (rst)
        out_valid && !out_ready |=> out_valid && $stable(out_beat));

endmodule

/* hw/group_norm_2d.sv */
// Group norm 2D top, streams centered 2x2 tiles and per-group variance
`timescale 1ns/1ps

module group_norm_2d (
    input  logic                      clk,
    input  logic                      rst,

    input  group_norm_pkg::beat_t     in_beat,
    input  logic                      in_valid,
    output logic                      in_ready,

    output group_norm_pkg::out_beat_t out_beat,
    output logic                      out_valid,
    input  logic                      out_ready
);

    import group_norm_pkg::*;

    logic                     buf_wr_valid;
    logic                     buf_wr_ready;
    logic                     acc_valid;
    logic                     acc_ready;

    beat_t                    buf_beat;
    logic                     buf_valid;
    logic                     buf_ready;

    logic signed [DATA_W-1:0] mean;
    logic                     mean_valid;
    logic                     mean_ready;

    lane_in_t                 lanes [LANES];
    logic                     lane_valid;
    logic                     lane_ready;

    lane_out_t                lane_out [LANES];
    logic [LANES-1:0]         lane_item_ready;
    logic [LANES-1:0]         lane_valid_vec;
    logic [LANES-1:0]         lane_last;
    logic                     lane_out_valid;
    logic                     lane_out_ready;

    // Input split, a beat enters buffer and accumulator in the same cycle
    assign in_ready     = buf_wr_ready && acc_ready;
    assign buf_wr_valid = in_valid && acc_ready;
    assign acc_valid    = in_valid && buf_wr_ready;

    group_buffer #(
        .payload_t (beat_t),
        .DEPTH     (BUF_DEPTH)
    ) i_group_buffer (
        .clk      (clk),
        .rst      (rst),
        .wr_data  (in_beat),
        .wr_valid (buf_wr_valid),
        .wr_ready (buf_wr_ready),
        .rd_data  (buf_beat),
        .rd_valid (buf_valid),
        .rd_ready (buf_ready)
    );

    mean_accumulator i_mean_accumulator (
        .clk        (clk),
        .rst        (rst),
        .beat       (in_beat),
        .beat_valid (acc_valid),
        .beat_ready (acc_ready),
        .mean       (mean),
        .mean_valid (mean_valid),
        .mean_ready (mean_ready)
    );

    norm_feeder i_norm_feeder (
        .clk        (clk),
        .rst        (rst),
        .mean       (mean),
        .mean_valid (mean_valid),
        .mean_ready (mean_ready),
        .beat       (buf_beat),
        .beat_valid (buf_valid),
        .beat_ready (buf_ready),
        .lanes      (lanes),
        .lane_valid (lane_valid),
        .lane_ready (lane_ready)
    );

    // Lanes move in lockstep on one shared handshake
    for (genvar i = 0; i < LANES; i++) begin : g_lane
        center_lane i_center_lane (
            .clk          (clk),
            .rst          (rst),
            .item         (lanes[i]),
            .item_valid   (lane_valid),
            .item_ready   (lane_item_ready[i]),
            .result       (lane_out[i]),
            .result_valid (lane_valid_vec[i]),
            .result_ready (lane_out_ready),
            .last         (lane_last[i])
        );
    end

    assign lane_ready     = &lane_item_ready;
    assign lane_out_valid = lane_valid_vec[0];

    variance_collector i_variance_collector (
        .clk           (clk),
        .rst           (rst),
        .results       (lane_out),
        .results_valid (lane_out_valid),
        .results_ready (lane_out_ready),
        .last          (lane_last[0]),
        .out_beat      (out_beat),
        .out_valid     (out_valid),
        .out_ready     (out_ready)
    );

    // All lane stages must agree on valid and on the group boundary
    assert property (@(posedge clk) disable iff (rst)
        (lane_valid_vec == '0) || (lane_valid_vec == '1));

    assert property (@(posedge clk) disable iff (rst)
        lane_out_valid |-> (lane_last == '0) || (lane_last == '1));

endmodule

/* tests/tb_group_norm_2d.sv */
// Group norm 2D testbench that checks directed groups against a reference model of the statistics
`timescale 1ns/1ps

module tb_group_norm_2d;

    import group_norm_pkg::*;

    localparam int TIMEOUT_CYCLES = 200;

    logic      clk;
    logic      rst;
    beat_t     in_beat;
    logic      in_valid;
    logic      in_ready;
    out_beat_t out_beat;
    logic      out_valid;
    logic      out_ready;

    // Current group values, indexed by beat then lane
    int        grp [GROUP_BEATS][LANES];
    out_beat_t exp_q [$];
    out_beat_t exp_beat;
    integer    seed = 32'h970713a3;
    integer    stall_seed;
    logic      random_stall;

    group_norm_2d i_group_norm_2d (
        .clk       (clk),
        .rst       (rst),
        .in_beat   (in_beat),
        .in_valid  (in_valid),
        .in_ready  (in_ready),
        .out_beat  (out_beat),
        .out_valid (out_valid),
        .out_ready (out_ready)
    );

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    task automatic report_failure();
        $display("Test failures found");
        $fatal(1, "Stopping at first error");
    endtask

    // Random out_ready pattern that changes just after each rising edge
    always @(posedge clk) begin
        #1;
        if (random_stall) begin
            out_ready = ($random(stall_seed) & 3) != 0;
        end
    end

    task automatic check_beat(input out_beat_t got, input out_beat_t exp);
        for (int l = 0; l < LANES; l++) begin
            assert (got.diff[l] === exp.diff[l]) else begin
                $display("FAILED out_beat.diff[%0d]: got %h expected %h",
                         l, got.diff[l], exp.diff[l]);
                report_failure();
            end
        end
        assert (got.last === exp.last) else begin
            $display("FAILED out_beat.last: got %h expected %h", got.last, exp.last);
            report_failure();
        end
        assert (got.variance === exp.variance) else begin
            $display("FAILED out_beat.variance: got %h expected %h",
                     got.variance, exp.variance);
            report_failure();
        end
    endtask

    // Output side is stable at the falling edge, and a beat seen here transfers next edge
    always @(negedge clk) begin
        if (!rst && out_valid && out_ready) begin
            assert (exp_q.size() != 0) else begin
                $display("An output beat arrived when none was expected");
                report_failure();
            end
            exp_beat = exp_q.pop_front();
            check_beat(out_beat, exp_beat);
        end
    end

    // Reference model with floor mean and floor variance over the 32 values
    task automatic push_expected();
        int        sum;
        int        mean;
        int        d;
        int        ssq;
        out_beat_t e;
        sum = 0;
        ssq = 0;
        for (int b = 0; b < GROUP_BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                sum += grp[b][l];
            end
        end
        mean = sum >>> GROUP_SHIFT;
        for (int b = 0; b < GROUP_BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                d = grp[b][l] - mean;
                e.diff[l] = DIFF_W'(d);
                ssq += d * d;
            end
            e.last = (b == GROUP_BEATS - 1);
            e.variance = e.last ? VAR_W'(ssq >>> GROUP_SHIFT) : '0;
            exp_q.push_back(e);
        end
    endtask

    function automatic beat_t make_beat(input int b);
        beat_t bt;
        for (int l = 0; l < LANES; l++) begin
            bt.data[l] = DATA_W'(grp[b][l]);
        end
        bt.last = (b == GROUP_BEATS - 1);
        return bt;
    endfunction

    task automatic fill_random();
        logic [31:0] r;
        for (int b = 0; b < GROUP_BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                r = $random(seed);
                grp[b][l] = $signed(r[7:0]);
            end
        end
    endtask

    // Starts just after a rising edge and returns just after the edge of the transfer
    task automatic drive_beat(input beat_t b);
        int waited;
        waited   = 0;
        in_beat  = b;
        in_valid = 1'b1;
        @(negedge clk);
        while (!in_ready) begin
            waited++;
            assert (waited < TIMEOUT_CYCLES) else begin
                $display("Timed out waiting for in_ready to accept a beat");
                report_failure();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
    endtask

    task automatic send_beats(input int count);
        for (int b = 0; b < count; b++) begin
            drive_beat(make_beat(b));
        end
        in_valid = 1'b0;
    endtask

    task automatic send_group();
        push_expected();
        send_beats(GROUP_BEATS);
    endtask

    task automatic wait_drain();
        int waited;
        waited = 0;
        while (exp_q.size() != 0) begin
            @(posedge clk);
            waited++;
            assert (waited < TIMEOUT_CYCLES) else begin
                $display("Timed out waiting for the expected output beats");
                report_failure();
            end
        end
        @(posedge clk);
        #1;
    endtask

    task automatic apply_reset();
        rst      = 1'b1;
        in_valid = 1'b0;
        repeat (3) @(posedge clk);
        #1;
        rst = 1'b0;
        assert (out_valid === 1'b0) else begin
            $display("FAILED out_valid: got %h expected %h", out_valid, 1'b0);
            report_failure();
        end
    endtask

    task automatic small_positive_group();
        for (int b = 0; b < GROUP_BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                grp[b][l] = (b * LANES + l) % 7 + 1;
            end
        end
        send_group();
        wait_drain();
    endtask

    // Sum is -63, so a floor mean of -2 rather than a truncated -1
    task automatic negative_mean_group();
        for (int b = 0; b < GROUP_BEATS; b++) begin
            for (int l = 0; l < LANES; l++) begin
                grp[b][l] = -((b * LANES + l) % 3) - 1;
            end
        end
        send_group();
        wait_drain();
    endtask

    task automatic back_to_back_groups();
        for (int g = 0; g < 3; g++) begin
            fill_random();
            send_group();
        end
        wait_drain();
    endtask

    task automatic ready_pulse_groups();
        stall_seed   = seed;
        random_stall = 1'b1;
        for (int g = 0; g < 2; g++) begin
            fill_random();
            send_group();
        end
        wait_drain();
        random_stall = 1'b0;
        out_ready    = 1'b1;
    endtask

    task automatic stalled_output_groups();
        int waited;
        waited    = 0;
        out_ready = 1'b0;
        for (int g = 0; g < 2; g++) begin
            fill_random();
            send_group();
        end
        @(negedge clk);
        while (in_ready) begin
            waited++;
            assert (waited < TIMEOUT_CYCLES) else begin
                $display("Timed out waiting for in_ready to drop under a stalled output");
                report_failure();
            end
            @(negedge clk);
        end
        @(posedge clk);
        #1;
        // The next group's first beat must stay blocked
        fill_random();
        in_beat  = make_beat(0);
        in_valid = 1'b1;
        repeat (20) begin
            @(negedge clk);
            assert (!in_ready) else begin
                $display("in_ready rose while the output was held stalled");
                report_failure();
            end
        end
        @(posedge clk);
        #1;
        out_ready = 1'b1;
        send_group();
        wait_drain();
    endtask

    task automatic reset_mid_group();
        fill_random();
        send_beats(3);
        apply_reset();
        fill_random();
        send_group();
        wait_drain();
    endtask

    initial begin
        rst          = 1'b1;
        in_beat      = '0;
        in_valid     = 1'b0;
        out_ready    = 1'b1;
        random_stall = 1'b0;
        apply_reset();
        small_positive_group();
        negative_mean_group();
        back_to_back_groups();
        ready_pulse_groups();
        stalled_output_groups();
        reset_mid_group();
        $display("All tests passed!");
        $finish;
    end

endmodule

/* flist.f */
hw/group_norm_pkg.sv
hw/group_buffer.sv
hw/mean_accumulator.sv
hw/norm_feeder.sv
hw/center_lane.sv
hw/variance_collector.sv
hw/group_norm_2d.sv
tests/tb_group_norm_2d.sv

/* Bender.yml */
package:
  name: group_norm_2d

sources:
  - hw/group_norm_pkg.sv
  - hw/group_buffer.sv
  - hw/mean_accumulator.sv
  - hw/norm_feeder.sv
  - hw/center_lane.sv
  - hw/variance_collector.sv
  - hw/group_norm_2d.sv
  - target: test
    files:
      - tests/tb_group_norm_2d.sv
